/* dbg_cpu.f */
+incdir+source
source/dbg_cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/debug_unit.sv
source/dbg_cpu_top.sv
test/dbg_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dbg_cpu_tb -f dbg_cpu.f \
    || { echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/Vdbg_cpu_tb)
echo "$sim_out"
echo "$sim_out" | grep -qx "TESTBENCH PASSED" && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }

/* source/dbg_cpu_consts.svh */
`ifndef DBG_CPU_CONSTS_SVH
`define DBG_CPU_CONSTS_SVH

// datapath widths and memory sizes.
`define DBG_XLEN        16
`define DBG_ILEN        16
`define DBG_NREGS       16
`define DBG_IMEM_DEPTH  64
`define DBG_PC_W        6
`define DBG_STATE_W     4

// host command bytes.
`define DBG_CMD_LOAD      8'h01
`define DBG_CMD_RUN       8'h02
`define DBG_CMD_STEP      8'h03
`define DBG_CMD_READ_REG  8'h04
`define DBG_CMD_READ_PC   8'h05
`define DBG_CMD_RESET_CPU 8'h06

`endif

/* source/dbg_cpu_pkg.sv */
`include "dbg_cpu_consts.svh"
`default_nettype none

package dbg_cpu_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_LDI  = 4'h5,
        OP_ADDI = 4'h6,
        OP_HALT = 4'hF
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
    } instr_rr_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] rd;
        logic [7:0] imm;
    } instr_imm_t;

    // opcode and rd sit in the same bits in both formats.
    typedef union packed {
        instr_rr_t  rr;
        instr_imm_t imm;
    } instr_u;

    typedef struct packed {
        logic                 valid;
        logic [`DBG_PC_W-1:0] pc;
        logic [`DBG_ILEN-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic                           valid;
        opcode_e                        opcode;
        logic [$clog2(`DBG_NREGS)-1:0]  rd;
        logic [`DBG_XLEN-1:0]           a;
        logic [`DBG_XLEN-1:0]           b;
    } decode_t;

    typedef struct packed {
        logic                           valid;
        logic [$clog2(`DBG_NREGS)-1:0]  rd;
        logic [`DBG_XLEN-1:0]           data;
    } wb_t;

    typedef enum logic [`DBG_STATE_W-1:0] {
        ST_IDLE      = 4'd0,
        ST_LOAD_ADDR = 4'd1,
        ST_LOAD_HI   = 4'd2,
        ST_LOAD_LO   = 4'd3,
        ST_REG_IDX   = 4'd4,
        ST_SEND_LO   = 4'd5
    } dbg_state_e;

endpackage

`default_nettype wire

/* source/dbg_cpu_top.sv */
`timescale 1ns/1ps
`include "dbg_cpu_consts.svh"
`default_nettype none

module dbg_cpu_top (
    input  wire                     i_clock,
    input  wire                     i_arst_n,
    input  wire [7:0]               i_rx_data,
    input  wire                     i_rx_valid,
    output wire [7:0]               o_tx_data,
    output wire                     o_tx_valid,
    output wire                     o_hlt,
    output wire [`DBG_STATE_W-1:0]  o_state
);

    wire [`DBG_PC_W-1:0]            pc;
    wire [`DBG_XLEN-1:0]            reg_data;
    wire [$clog2(`DBG_NREGS)-1:0]   reg_addr;
    wire                            imem_we;
    wire [`DBG_PC_W-1:0]            imem_addr;
    wire [`DBG_ILEN-1:0]            imem_data;
    wire                            enable;
    wire                            clear;
    wire dbg_cpu_pkg::fetch_t       fetch;
    wire dbg_cpu_pkg::decode_t      decode;
    wire dbg_cpu_pkg::wb_t          wb;

    debug_unit u_debug_unit (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_rx_data   (i_rx_data),
        .i_rx_valid  (i_rx_valid),
        .i_pc        (pc),
        .i_hlt       (o_hlt),
        .i_reg_data  (reg_data),
        .o_reg_addr  (reg_addr),
        .o_imem_we   (imem_we),
        .o_imem_addr (imem_addr),
        .o_imem_data (imem_data),
        .o_enable    (enable),
        .o_clear     (clear),
        .o_tx_data   (o_tx_data),
        .o_tx_valid  (o_tx_valid),
        .o_state     (o_state)
    );

    fetch_stage u_fetch (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_enable    (enable),
        .i_clear     (clear),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_pc        (pc),
        .o_fetch     (fetch)
    );

    decode_stage u_decode (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_enable       (enable),
        .i_clear        (clear),
        .i_fetch        (fetch),
        .i_wb           (wb),
        .i_dbg_reg_addr (reg_addr),
        .o_dbg_reg_data (reg_data),
        .o_decode       (decode)
    );

    execute_stage u_execute (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_enable (enable),
        .i_clear  (clear),
        .i_decode (decode),
        .o_wb     (wb),
        .o_hlt    (o_hlt)
    );

endmodule

`default_nettype wire

/* source/debug_unit.sv */
`timescale 1ns/1ps
`include "dbg_cpu_consts.svh"
`default_nettype none

module debug_unit (
    input  wire                             i_clock,
    input  wire                             i_arst_n,
    input  wire [7:0]                       i_rx_data,
    input  wire                             i_rx_valid,
    input  wire [`DBG_PC_W-1:0]             i_pc,
    input  wire                             i_hlt,
    input  wire [`DBG_XLEN-1:0]             i_reg_data,
    output logic [$clog2(`DBG_NREGS)-1:0]   o_reg_addr,
    output logic                            o_imem_we,
    output logic [`DBG_PC_W-1:0]            o_imem_addr,
    output logic [`DBG_ILEN-1:0]            o_imem_data,
    output logic                            o_enable,
    output logic                            o_clear,
    output logic [7:0]                      o_tx_data,
    output logic                            o_tx_valid,
    output dbg_cpu_pkg::dbg_state_e         o_state
);

    import dbg_cpu_pkg::*;

    localparam int REG_W = $clog2(`DBG_NREGS);

    dbg_state_e       state_q;
    logic [REG_W-1:0] reg_addr_q;
    logic             run_q;
    logic             step_q;

    assign o_state  = state_q;
    assign o_enable = (run_q || step_q) && !i_hlt;

    // the index byte addresses the file directly so the high byte can leave next cycle.
    assign o_reg_addr = (state_q == ST_REG_IDX) ? i_rx_data[REG_W-1:0] : reg_addr_q;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= ST_IDLE;
            run_q      <= 1'b0;
            step_q     <= 1'b0;
            o_clear    <= 1'b0;
            o_imem_we  <= 1'b0;
            o_tx_valid <= 1'b0;
        end else begin
            step_q     <= 1'b0;
            o_clear    <= 1'b0;
            o_imem_we  <= 1'b0;
            o_tx_valid <= 1'b0;
            if (i_hlt) begin
                run_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (i_rx_valid) begin
                        case (i_rx_data)
                            `DBG_CMD_LOAD:     state_q <= ST_LOAD_ADDR;
                            `DBG_CMD_RUN:      run_q <= 1'b1;
                            `DBG_CMD_STEP:     step_q <= 1'b1;
                            `DBG_CMD_READ_REG: state_q <= ST_REG_IDX;
                            `DBG_CMD_READ_PC:  o_tx_valid <= 1'b1;
                            `DBG_CMD_RESET_CPU: begin
                                o_clear <= 1'b1;
                                run_q   <= 1'b0;
                            end
                            default: state_q <= ST_IDLE;
                        endcase
                    end
                end
                ST_LOAD_ADDR: begin
                    if (i_rx_valid) begin
                        state_q <= ST_LOAD_HI;
                    end
                end
                ST_LOAD_HI: begin
                    if (i_rx_valid) begin
                        state_q <= ST_LOAD_LO;
                    end
                end
                ST_LOAD_LO: begin
                    if (i_rx_valid) begin
                        o_imem_we <= 1'b1;
                        state_q   <= ST_IDLE;
                    end
                end
                ST_REG_IDX: begin
                    if (i_rx_valid) begin
                        o_tx_valid <= 1'b1;
                        state_q    <= ST_SEND_LO;
                    end
                end
                ST_SEND_LO: begin
                    o_tx_valid <= 1'b1;
                    state_q    <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // argument and response bytes, qualified by the strobes above.
    always_ff @(posedge i_clock) begin
        case (state_q)
            ST_IDLE: begin
                if (i_rx_valid) begin
                    o_tx_data <= {{(8 - `DBG_PC_W){1'b0}}, i_pc};
                end
            end
            ST_LOAD_ADDR: begin
                if (i_rx_valid) begin
                    o_imem_addr <= i_rx_data[`DBG_PC_W-1:0];
                end
            end
            ST_LOAD_HI: begin
                if (i_rx_valid) begin
                    o_imem_data[`DBG_ILEN-1 -: 8] <= i_rx_data;
                end
            end
            ST_LOAD_LO: begin
                if (i_rx_valid) begin
                    o_imem_data[7:0] <= i_rx_data;
                end
            end
            ST_REG_IDX: begin
                if (i_rx_valid) begin
                    reg_addr_q <= i_rx_data[REG_W-1:0];
                    o_tx_data  <= i_reg_data[`DBG_XLEN-1 -: 8];
                end
            end
            ST_SEND_LO: o_tx_data <= i_reg_data[7:0];
            default: o_tx_data <= o_tx_data;
        endcase
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ps
`include "dbg_cpu_consts.svh"
`default_nettype none

module decode_stage (
    input  wire                                 i_clock,
    input  wire                                 i_arst_n,
    input  wire                                 i_enable,
    input  wire                                 i_clear,
    input  wire dbg_cpu_pkg::fetch_t            i_fetch,
    input  wire dbg_cpu_pkg::wb_t               i_wb,
    input  wire [$clog2(`DBG_NREGS)-1:0]        i_dbg_reg_addr,
    output logic [`DBG_XLEN-1:0]                o_dbg_reg_data,
    output dbg_cpu_pkg::decode_t                o_decode
);

    import dbg_cpu_pkg::*;

    localparam int REG_W = $clog2(`DBG_NREGS);

    logic [`DBG_XLEN-1:0] regs [`DBG_NREGS];

    instr_u               word;
    logic                 is_imm;
    logic [REG_W-1:0]     a_idx;
    logic [REG_W-1:0]     b_idx;
    logic [`DBG_XLEN-1:0] a_val;
    logic [`DBG_XLEN-1:0] b_val;
    logic [`DBG_XLEN-1:0] imm_val;

    assign word   = i_fetch.instr;
    assign is_imm = (word.rr.opcode == OP_LDI) || (word.rr.opcode == OP_ADDI);

    // addi accumulates into rd, so rd is also its first source.
    assign a_idx = is_imm ? word.imm.rd : word.rr.rs;
    assign b_idx = word.rr.rt;

    // imm8 is zero extended.
    assign imm_val = {{(`DBG_XLEN - 8){1'b0}}, word.imm.imm};

    // the result leaving execute this cycle is not yet in the file.
    assign a_val = (i_wb.valid && (i_wb.rd == a_idx)) ? i_wb.data : regs[a_idx];
    assign b_val = (i_wb.valid && (i_wb.rd == b_idx)) ? i_wb.data : regs[b_idx];

    assign o_dbg_reg_data = regs[i_dbg_reg_addr];

    // registers survive a processor clear and only the pin reset zeroes them.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `DBG_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_enable && i_wb.valid) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_decode <= '0;
        end else if (i_clear) begin
            o_decode.valid <= 1'b0;
        end else if (i_enable) begin
            o_decode.valid  <= i_fetch.valid;
            o_decode.opcode <= word.rr.opcode;
            o_decode.rd     <= word.rr.rd;
            o_decode.a      <= a_val;
            o_decode.b      <= is_imm ? imm_val : b_val;
        end
    end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ps
`include "dbg_cpu_consts.svh"
`default_nettype none

module execute_stage (
    input  wire                         i_clock,
    input  wire                         i_arst_n,
    input  wire                         i_enable,
    input  wire                         i_clear,
    input  wire dbg_cpu_pkg::decode_t   i_decode,
    output dbg_cpu_pkg::wb_t            o_wb,
    output logic                        o_hlt
);

    import dbg_cpu_pkg::*;

    logic [`DBG_XLEN-1:0] result;
    logic                 writes;

    // all arithmetic wraps at the register width.
    always_comb begin
        result = '0;
        writes = 1'b1;
        case (i_decode.opcode)
            OP_ADD:  result = i_decode.a + i_decode.b;
            OP_SUB:  result = i_decode.a - i_decode.b;
            OP_AND:  result = i_decode.a & i_decode.b;
            OP_XOR:  result = i_decode.a ^ i_decode.b;
            OP_LDI:  result = i_decode.b;
            OP_ADDI: result = i_decode.a + i_decode.b;
            default: writes = 1'b0;
        endcase
    end

    always_comb begin
        o_wb.valid = i_decode.valid && writes;
        o_wb.rd    = i_decode.rd;
        o_wb.data  = result;
    end

    // halt stays set until the debug unit clears the processor.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_hlt <= 1'b0;
        end else if (i_clear) begin
            o_hlt <= 1'b0;
        end else if (i_enable && i_decode.valid && (i_decode.opcode == OP_HALT)) begin
            o_hlt <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`timescale 1ns/1ps
`include "dbg_cpu_consts.svh"
`default_nettype none

module fetch_stage (
    input  wire                   i_clock,
    input  wire                   i_arst_n,
    input  wire                   i_enable,
    input  wire                   i_clear,
    input  wire                   i_imem_we,
    input  wire [`DBG_PC_W-1:0]   i_imem_addr,
    input  wire [`DBG_ILEN-1:0]   i_imem_data,
    output logic [`DBG_PC_W-1:0]  o_pc,
    output dbg_cpu_pkg::fetch_t   o_fetch
);

    import dbg_cpu_pkg::*;

    logic [`DBG_ILEN-1:0] imem [`DBG_IMEM_DEPTH];

    // the debug unit is the only writer of program memory.
    always_ff @(posedge i_clock) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= '0;
        end else if (i_clear) begin
            o_pc <= '0;
        end else if (i_enable) begin
            o_pc <= o_pc + 1'b1;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_fetch <= '0;
        end else if (i_clear) begin
            o_fetch.valid <= 1'b0;
        end else if (i_enable) begin
            o_fetch.valid <= 1'b1;
            o_fetch.pc    <= o_pc;
            o_fetch.instr <= imem[o_pc];
        end
    end

endmodule

`default_nettype wire

/* test/dbg_cpu_tb.sv */
`timescale 1ns/1ps
`include "dbg_cpu_consts.svh"
`default_nettype none

module dbg_cpu_tb;

    import dbg_cpu_pkg::*;

    // the whole run needs well under a thousand cycles.
    localparam int CYCLE_LIMIT = 4000;
    localparam int RESP_WAIT   = 8;
    localparam int HALT_WAIT   = 200;

    logic                    i_clock;
    logic                    i_arst_n;
    logic [7:0]              i_rx_data;
    logic                    i_rx_valid;
    wire  [7:0]              o_tx_data;
    wire                     o_tx_valid;
    wire                     o_hlt;
    wire  [`DBG_STATE_W-1:0] o_state;

    logic [15:0] model_regs [16];
    integer      seed;
    int          value_errors;
    int          missing_errors;
    int          cycle_count;

    dbg_cpu_top DUT (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rx_data  (i_rx_data),
        .i_rx_valid (i_rx_valid),
        .o_tx_data  (o_tx_data),
        .o_tx_valid (o_tx_valid),
        .o_hlt      (o_hlt),
        .o_state    (o_state)
    );

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge i_clock);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing the tests", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [15:0] enc_rr(opcode_e op, logic [3:0] rd, logic [3:0] rs,
                                           logic [3:0] rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic logic [15:0] enc_imm(opcode_e op, logic [3:0] rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // one byte is presented for exactly one clock.
    task automatic send_byte(input logic [7:0] b);
        @(posedge i_clock);
        i_rx_data  <= b;
        i_rx_valid <= 1'b1;
        @(posedge i_clock);
        i_rx_valid <= 1'b0;
    endtask

    task automatic capture_byte(output logic [7:0] b, output logic got);
        got = 1'b0;
        b   = '0;
        for (int i = 0; i < RESP_WAIT && !got; i++) begin
            @(negedge i_clock);
            if (o_tx_valid) begin
                got = 1'b1;
                b   = o_tx_data;
            end
        end
    endtask

    task automatic load_instr(input logic [5:0] addr, input logic [15:0] word);
        send_byte(`DBG_CMD_LOAD);
        send_byte({2'b00, addr});
        send_byte(word[15:8]);
        send_byte(word[7:0]);
    endtask

    task automatic read_reg(input logic [3:0] idx, output logic [15:0] value);
        logic [7:0] hi;
        logic       got;
        send_byte(`DBG_CMD_READ_REG);
        send_byte({4'h0, idx});
        capture_byte(hi, got);
        assert (got) else begin
            $display("no high byte came back for READ_REG of r%0d", idx);
            missing_errors++;
        end
        @(negedge i_clock);
        assert (o_tx_valid) else begin
            $display("low byte for READ_REG of r%0d did not follow on the next cycle", idx);
            missing_errors++;
        end
        value = {hi, o_tx_data};
    endtask

    task automatic read_pc(output logic [7:0] value);
        logic got;
        send_byte(`DBG_CMD_READ_PC);
        capture_byte(value, got);
        assert (got) else begin
            $display("no byte came back for READ_PC");
            missing_errors++;
        end
    endtask

    task automatic check_reg(input logic [3:0] idx);
        logic [15:0] value;
        read_reg(idx, value);
        check_value($sformatf("r%0d", idx), value, model_regs[idx]);
    endtask

    task automatic check_all_regs();
        for (int r = 0; r < 16; r++) begin
            check_reg(r[3:0]);
        end
    endtask

    task automatic check_pc(input logic [7:0] exp);
        logic [7:0] pc;
        read_pc(pc);
        check_value("pc", {8'h00, pc}, {8'h00, exp});
    endtask

    task automatic wait_for_halt(input string label);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < HALT_WAIT && !seen; i++) begin
            @(negedge i_clock);
            seen = o_hlt;
        end
        assert (seen) else begin
            $display("processor never halted during %s", label);
            missing_errors++;
        end
    endtask

    task automatic test_reset_state();
        @(negedge i_clock);
        check_value("o_hlt after reset", {15'h0, o_hlt}, 16'h0);
        check_value("o_state after reset", 16'(o_state), 16'(ST_IDLE));
        check_pc(8'd0);
    endtask

    task automatic test_load_and_run();
        logic [7:0] imm_a;
        logic [7:0] imm_b;
        imm_a = 8'($random(seed));
        imm_b = 8'($random(seed));
        load_instr(6'd0, enc_imm(OP_LDI, 4'd1, imm_a));
        load_instr(6'd1, enc_imm(OP_LDI, 4'd2, imm_b));
        load_instr(6'd2, enc_rr(OP_ADD, 4'd3, 4'd1, 4'd2));
        load_instr(6'd3, enc_rr(OP_SUB, 4'd4, 4'd1, 4'd3));
        load_instr(6'd4, enc_rr(OP_AND, 4'd5, 4'd4, 4'd2));
        load_instr(6'd5, enc_rr(OP_XOR, 4'd6, 4'd5, 4'd3));
        load_instr(6'd6, enc_rr(OP_HALT, 4'd0, 4'd0, 4'd0));
        model_regs[1] = {8'h00, imm_a};
        model_regs[2] = {8'h00, imm_b};
        model_regs[3] = model_regs[1] + model_regs[2];
        model_regs[4] = model_regs[1] - model_regs[3];
        model_regs[5] = model_regs[4] & model_regs[2];
        model_regs[6] = model_regs[5] ^ model_regs[3];
        send_byte(`DBG_CMD_RUN);
        wait_for_halt("the first program");
        check_all_regs();
    endtask

    // halt at address 6 leaves the pc three words further on.
    task automatic test_halted_step();
        check_pc(8'd9);
        send_byte(`DBG_CMD_STEP);
        check_pc(8'd9);
        check_all_regs();
    endtask

    task automatic test_reset_and_step();
        logic [15:0] old_value;
        logic [7:0]  new_imm;
        logic        cleared;
        old_value = model_regs[1];
        new_imm   = old_value[7:0] ^ 8'hA5;
        load_instr(6'd0, enc_imm(OP_LDI, 4'd1, new_imm));
        send_byte(`DBG_CMD_RESET_CPU);
        // the clear pulse is registered, so halt drops on the edge after it.
        cleared = 1'b0;
        for (int i = 0; i < RESP_WAIT && !cleared; i++) begin
            @(negedge i_clock);
            cleared = !o_hlt;
        end
        check_value("o_hlt after RESET_CPU", {15'h0, o_hlt}, 16'h0);
        send_byte(`DBG_CMD_STEP);
        send_byte(`DBG_CMD_STEP);
        check_reg(4'd1);
        send_byte(`DBG_CMD_STEP);
        model_regs[1] = {8'h00, new_imm};
        check_reg(4'd1);
        check_pc(8'd3);
    endtask

    task automatic test_addi_chain();
        logic [7:0] imm;
        imm = 8'($random(seed));
        load_instr(6'd0, enc_imm(OP_LDI, 4'd7, imm));
        model_regs[7] = {8'h00, imm};
        for (int i = 1; i < 4; i++) begin
            imm = 8'($random(seed));
            load_instr(i[5:0], enc_imm(OP_ADDI, 4'd7, imm));
            model_regs[7] = model_regs[7] + {8'h00, imm};
        end
        load_instr(6'd4, enc_rr(OP_HALT, 4'd0, 4'd0, 4'd0));
        send_byte(`DBG_CMD_RESET_CPU);
        send_byte(`DBG_CMD_RUN);
        wait_for_halt("the ADDI chain");
        check_pc(8'd7);
        check_all_regs();
    endtask

    initial begin
        i_arst_n       = 1'b0;
        i_rx_data      = 8'h00;
        i_rx_valid     = 1'b0;
        seed           = 93417;
        value_errors   = 0;
        missing_errors = 0;
        for (int r = 0; r < 16; r++) begin
            model_regs[r] = 16'h0000;
        end
        repeat (16) @(posedge i_clock);
        i_arst_n <= 1'b1;

        test_reset_state();
        test_load_and_run();
        test_halted_step();
        test_reset_and_step();
        test_addi_chain();

        $display("value errors: %0d, missing responses: %0d", value_errors, missing_errors);
        if (value_errors == 0 && missing_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
